// ==== aesCbc.f ====
src/aesPkg.sv
src/keyExpand.sv
src/mixColumns.sv
src/aesRound.sv
src/aesIterCore.sv
src/cbcChain.sv
src/aesCbcTop.sv
verification/aesCbc_props.sv
verification/aesCbcTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
SIMFLAGS  ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= aesCbcTb
FILELIST  ?= aesCbc.f
OBJDIR    ?= obj_dir
PASSMSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== verification/aesCbcTb.sv ====
//--------------------------------------------------------------------------
// Directed testbench for the AES-128 CBC top level: known answers, a CBC
// round trip and credit back-pressure. Run it as the simulation top.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aesCbcTb;
  import aesPkg::*;

  localparam int InDelay = 10;
  // the tests need about 600 cycles
  localparam int MaxCycles = 2000;
  localparam int FullLatency = 21;
  localparam aesBlock_t KatKey = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aesBlock_t KatPlain = 128'h00112233445566778899aabbccddeeff;
  localparam aesBlock_t KatCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic clk = 1'b0;
  logic rst;
  logic chainRestart;
  logic inValid;
  aesReq_t inReq;
  logic inCreditReturn;
  logic outCreditGrant;
  logic outValid;
  aesBlock_t outBlock;
  int cycleCount = 0;
  logic inCredit;

  aesCbcTop #(.OutCreditMax(4)) i_dut (
    .clk            (clk),
    .rst            (rst),
    .chainRestart   (chainRestart),
    .inValid        (inValid),
    .inReq          (inReq),
    .inCreditReturn (inCreditReturn),
    .outCreditGrant (outCreditGrant),
    .outValid       (outValid),
    .outBlock       (outBlock)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic nextCycle();
    @(posedge clk);
    #InDelay;
  endtask

  task automatic checkValue(input aesBlock_t actual, input aesBlock_t expected,
                            input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic restartChain();
    chainRestart = 1'b1;
    nextCycle();
    chainRestart = 1'b0;
  endtask

  task automatic grantCredits(input int count);
    repeat (count) begin
      outCreditGrant = 1'b1;
      nextCycle();
    end
    outCreditGrant = 1'b0;
  endtask

  task automatic sendBlock(input aesBlock_t blk, input aesBlock_t key, input aesMode_t mode);
    if (!inCredit) begin
      $display("Upstream tried to send a block without holding an input credit");
      $display("RESULT: FAIL");
      $fatal(1, "input credit protocol broken");
    end
    inReq.block = blk;
    inReq.key = key;
    inReq.mode = mode;
    inValid = 1'b1;
    inCredit = 1'b0;
    nextCycle();
    inValid = 1'b0;
  endtask

  // latency counts cycles since the send, valid only when called right after it
  task automatic waitResult(output aesBlock_t blk, output int latency);
    latency = 1;
    while (!outValid) begin
      nextCycle();
      latency++;
    end
    checkValue(aesBlock_t'(inCreditReturn), aesBlock_t'(1), "credit return with outValid");
    blk = outBlock;
    inCredit = 1'b1;
    nextCycle();
  endtask

  task automatic holdOff(input int cycles, input string msg);
    repeat (cycles) begin
      checkValue(aesBlock_t'(outValid), '0, msg);
      checkValue(aesBlock_t'(inCreditReturn), '0, msg);
      nextCycle();
    end
  endtask

  function automatic aesBlock_t randomBlock();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic runOne(input aesBlock_t blk, input aesBlock_t key, input aesMode_t mode,
                        input aesBlock_t expected, input string msg);
    aesBlock_t res;
    int latency;
    sendBlock(blk, key, mode);
    waitResult(res, latency);
    checkValue(res, expected, msg);
    checkValue(aesBlock_t'(latency), aesBlock_t'(FullLatency), {msg, " latency"});
  endtask

  task automatic testReset();
    holdOff(30, "output quiet after reset");
  endtask

  task automatic testKnownAnswer();
    restartChain();
    grantCredits(1);
    runOne(KatPlain, KatKey, modeEncrypt, KatCipher, "known-answer encrypt");
    restartChain();
    grantCredits(1);
    runOne(KatCipher, KatKey, modeDecrypt, KatPlain, "known-answer decrypt");
  endtask

  task automatic testRoundTrip();
    aesBlock_t key;
    aesBlock_t plain [4];
    aesBlock_t cipher [4];
    int latency;
    key = randomBlock();
    for (int i = 0; i < 4; i++) begin
      plain[i] = randomBlock();
    end
    // identical plaintexts must still chain to distinct ciphertexts
    plain[1] = plain[0];
    restartChain();
    for (int i = 0; i < 4; i++) begin
      grantCredits(1);
      sendBlock(plain[i], key, modeEncrypt);
      waitResult(cipher[i], latency);
    end
    checkValue(aesBlock_t'(cipher[0] == cipher[1]), '0, "chained ciphertexts differ");
    restartChain();
    for (int i = 0; i < 4; i++) begin
      grantCredits(1);
      runOne(cipher[i], key, modeDecrypt, plain[i], "CBC round trip");
    end
  endtask

  task automatic testBackPressure();
    aesBlock_t res;
    int latency;
    restartChain();
    sendBlock(KatPlain, KatKey, modeEncrypt);
    holdOff(40, "held without output credit");
    grantCredits(1);
    waitResult(res, latency);
    checkValue(res, KatCipher, "block released by a credit");
    holdOff(5, "single delivery per credit");
    // six grants saturate the counter at four
    grantCredits(6);
    for (int i = 0; i < 4; i++) begin
      restartChain();
      runOne(KatCipher, KatKey, modeDecrypt, KatPlain, "pre-granted credit");
    end
    restartChain();
    sendBlock(KatCipher, KatKey, modeDecrypt);
    holdOff(40, "fifth block waits for a credit");
    grantCredits(1);
    waitResult(res, latency);
    checkValue(res, KatPlain, "fifth block after new credit");
  endtask

  initial begin
    void'($urandom(45));
    rst = 1'b1;
    chainRestart = 1'b0;
    inValid = 1'b0;
    inReq = '0;
    outCreditGrant = 1'b0;
    inCredit = 1'b1;
    repeat (4) @(posedge clk);
    #InDelay;
    rst = 1'b0;
    testReset();
    testKnownAnswer();
    testRoundTrip();
    testBackPressure();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== verification/aesCbc_props.sv ====
//--------------------------------------------------------------------------
// Concurrent checks on the output handshake of the CBC top level, bound
// into every aesCbcTop instance.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aesCbcProps (
  input logic clk,
  input logic rst,
  input logic outValid,
  input logic inCreditReturn
);

  // a delivered result sends the core back to idle
  noBackToBack: assert property (@(posedge clk) disable iff (rst) outValid |=> !outValid)
    else $error("outValid was high in two consecutive cycles");

  creditFollowsOutput: assert property (@(posedge clk) disable iff (rst)
    inCreditReturn == outValid)
    else $error("inCreditReturn differs from outValid");

  quietAfterReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid was high in the cycle after reset");

endmodule

bind aesCbcTop aesCbcProps uProps (
  .clk            (clk),
  .rst            (rst),
  .outValid       (outValid),
  .inCreditReturn (inCreditReturn)
);

// ==== src/aesCbcTop.sv ====
//--------------------------------------------------------------------------
// AES-128 CBC top level with credit flow control. Upstream holds a single
// credit; downstream grants output credits up to OutCreditMax.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aesCbcTop #(
  parameter int OutCreditMax = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               chainRestart,
  input  logic               inValid,
  input  aesPkg::aesReq_t    inReq,
  output logic               inCreditReturn,
  input  logic               outCreditGrant,
  output logic               outValid,
  output aesPkg::aesBlock_t  outBlock
);

  localparam int CntWidth = $clog2(OutCreditMax + 1);

  logic [CntWidth-1:0] creditCnt;
  logic resultReady;
  logic resultTaken;
  logic grantAccepted;

  cbcChain uChain (
    .clk          (clk),
    .rst          (rst),
    .chainRestart (chainRestart),
    .inValid      (inValid),
    .inReq        (inReq),
    .resultTaken  (resultTaken),
    .resultReady  (resultReady),
    .chainOut     (outBlock)
  );

  // deliver only with an output credit in hand
  assign resultTaken = resultReady && (creditCnt != '0);
  assign grantAccepted = outCreditGrant && (creditCnt != CntWidth'(OutCreditMax));

  always_ff @(posedge clk) begin
    if (rst) begin
      creditCnt <= '0;
    end else begin
      creditCnt <= creditCnt + CntWidth'(grantAccepted) - CntWidth'(resultTaken);
    end
  end

  // the input credit comes back as the block leaves
  assign outValid = resultTaken;
  assign inCreditReturn = resultTaken;

endmodule

// ==== src/cbcChain.sv ====
//--------------------------------------------------------------------------
// CBC chaining around the iterative core. chainRestart zeroes the chain
// value, which then acts as an all-zero IV for the next block.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cbcChain (
  input  logic               clk,
  input  logic               rst,
  input  logic               chainRestart,
  input  logic               inValid,
  input  aesPkg::aesReq_t    inReq,
  input  logic               resultTaken,
  output logic               resultReady,
  output aesPkg::aesBlock_t  chainOut
);
  import aesPkg::*;

  aesBlock_t chainReg;
  aesBlock_t xorMask;
  aesBlock_t coreResult;
  aesMode_t blockMode;
  aesReq_t coreReq;

  // plaintext is whitened with the previous ciphertext before encryption
  always_comb begin
    coreReq = inReq;
    if (inReq.mode == modeEncrypt) begin
      coreReq.block = inReq.block ^ chainReg;
    end
  end

  aesIterCore uCore (
    .clk         (clk),
    .rst         (rst),
    .start       (inValid),
    .req         (coreReq),
    .resultTaken (resultTaken),
    .resultReady (resultReady),
    .resultBlock (coreResult)
  );

  assign chainOut = coreResult ^ xorMask;

  always_ff @(posedge clk) begin
    if (rst) begin
      chainReg <= '0;
    end else if (chainRestart) begin
      chainReg <= '0;
    end else if (inValid && inReq.mode == modeDecrypt) begin
      chainReg <= inReq.block;
    end else if (resultTaken && blockMode == modeEncrypt) begin
      chainReg <= chainOut;
    end
  end

  // decrypt xors with the chain value seen at accept time
  always_ff @(posedge clk) begin
    if (inValid) begin
      blockMode <= inReq.mode;
      xorMask <= (inReq.mode == modeDecrypt) ? chainReg : '0;
    end
  end

endmodule

// ==== src/aesIterCore.sv ====
//--------------------------------------------------------------------------
// Iterative AES-128 core. A start pulse loads one request; the result is
// held on resultBlock with resultReady high until resultTaken.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aesIterCore (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  aesPkg::aesReq_t    req,
  input  logic               resultTaken,
  output logic               resultReady,
  output aesPkg::aesBlock_t  resultBlock
);
  import aesPkg::*;

  coreState_t state;
  aesBlock_t stateReg;
  aesMode_t modeReg;
  roundIdx_t roundCnt;
  roundIdx_t keySel;
  aesBlock_t roundKey;
  aesBlock_t roundOut;
  logic keyStart;
  logic keysReady;
  logic lastRound;

  assign keyStart = start && (state == stIdle);

  // round 0 is the whitening step, decryption walks the keys backwards
  assign keySel = (modeReg == modeEncrypt) ? roundCnt : roundIdx_t'(NumRounds) - roundCnt;
  assign lastRound = (roundCnt == roundIdx_t'(NumRounds));

  keyExpand uKeyExpand (
    .clk       (clk),
    .rst       (rst),
    .keyStart  (keyStart),
    .cipherKey (req.key),
    .keySel    (keySel),
    .roundKey  (roundKey),
    .keysReady (keysReady)
  );

  aesRound uRound (
    .stateIn   (stateReg),
    .roundKey  (roundKey),
    .mode      (modeReg),
    .lastRound (lastRound),
    .stateOut  (roundOut)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
      roundCnt <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (start) begin
            state <= stExpand;
            roundCnt <= '0;
          end
        end
        stExpand: begin
          if (keysReady) begin
            state <= stRounds;
            roundCnt <= 4'd1;
          end
        end
        stRounds: begin
          if (lastRound) begin
            state <= stDone;
          end else begin
            roundCnt <= roundCnt + 4'd1;
          end
        end
        stDone: begin
          if (resultTaken) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (keyStart) begin
      stateReg <= req.block;
      modeReg <= req.mode;
    end else if (state == stExpand && keysReady) begin
      stateReg <= stateReg ^ roundKey;
    end else if (state == stRounds) begin
      stateReg <= roundOut;
    end
  end

  assign resultReady = (state == stDone);
  assign resultBlock = stateReg;

endmodule

// ==== src/aesRound.sv ====
//--------------------------------------------------------------------------
// One combinational AES round for either direction. lastRound drops the
// column mixing, as the final round of the cipher requires.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aesRound (
  input  aesPkg::aesBlock_t  stateIn,
  input  aesPkg::aesBlock_t  roundKey,
  input  aesPkg::aesMode_t   mode,
  input  logic               lastRound,
  output aesPkg::aesBlock_t  stateOut
);
  import aesPkg::*;

  aesBlock_t sbOut, srOut;
  aesBlock_t isrOut, isbOut, arkOut;
  aesBlock_t mixIn, mixOut;

  // row r rotates left by r bytes, or right for the inverse
  function automatic aesBlock_t shiftRows(input aesBlock_t blk, input logic inverse);
    aesBlock_t res;
    int src;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        src = inverse ? r + 4 * ((c + 4 - r) % 4) : r + 4 * ((c + r) % 4);
        res[BlockWidth-1-ByteWidth*(r+4*c) -: ByteWidth] =
          blk[BlockWidth-1-ByteWidth*src -: ByteWidth];
      end
    end
    return res;
  endfunction

  assign sbOut = subBytes(stateIn);
  assign srOut = shiftRows(sbOut, 1'b0);

  assign isrOut = shiftRows(stateIn, 1'b1);
  assign isbOut = invSubBytes(isrOut);
  assign arkOut = isbOut ^ roundKey;

  // one mixer serves both directions
  assign mixIn = (mode == modeEncrypt) ? srOut : arkOut;

  mixColumns uMixColumns (
    .colIn  (mixIn),
    .mode   (mode),
    .colOut (mixOut)
  );

  assign stateOut = (mode == modeEncrypt) ? ((lastRound ? srOut : mixOut) ^ roundKey)
                                          : (lastRound ? arkOut : mixOut);

endmodule

// ==== src/mixColumns.sv ====
//--------------------------------------------------------------------------
// MixColumns and InvMixColumns over GF(2^8), built from xtime chains only.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mixColumns (
  input  aesPkg::aesBlock_t  colIn,
  input  aesPkg::aesMode_t   mode,
  output aesPkg::aesBlock_t  colOut
);
  import aesPkg::*;

  logic [ByteWidth-1:0] b [NumBytes];
  logic [ByteWidth-1:0] x2 [NumBytes];
  logic [ByteWidth-1:0] x4 [NumBytes];
  logic [ByteWidth-1:0] x8 [NumBytes];
  logic [ByteWidth-1:0] m3 [NumBytes];
  logic [ByteWidth-1:0] m9 [NumBytes];
  logic [ByteWidth-1:0] m11 [NumBytes];
  logic [ByteWidth-1:0] m13 [NumBytes];
  logic [ByteWidth-1:0] m14 [NumBytes];
  logic [ByteWidth-1:0] fwd [NumBytes];
  logic [ByteWidth-1:0] inv [NumBytes];

  function automatic logic [7:0] xtime(input logic [7:0] v);
    return {v[6:0], 1'b0} ^ (8'h1b & {8{v[7]}});
  endfunction

  always_comb begin
    for (int i = 0; i < NumBytes; i++) begin
      b[i] = colIn[BlockWidth-1-ByteWidth*i -: ByteWidth];
      x2[i] = xtime(b[i]);
      x4[i] = xtime(x2[i]);
      x8[i] = xtime(x4[i]);
      m3[i] = x2[i] ^ b[i];
      m9[i] = x8[i] ^ b[i];
      m11[i] = x8[i] ^ x2[i] ^ b[i];
      m13[i] = x8[i] ^ x4[i] ^ b[i];
      m14[i] = x8[i] ^ x4[i] ^ x2[i];
    end
    // column c holds bytes 4c to 4c+3
    for (int c = 0; c < 4; c++) begin
      fwd[4*c]   = x2[4*c] ^ m3[4*c+1] ^ b[4*c+2] ^ b[4*c+3];
      fwd[4*c+1] = b[4*c] ^ x2[4*c+1] ^ m3[4*c+2] ^ b[4*c+3];
      fwd[4*c+2] = b[4*c] ^ b[4*c+1] ^ x2[4*c+2] ^ m3[4*c+3];
      fwd[4*c+3] = m3[4*c] ^ b[4*c+1] ^ b[4*c+2] ^ x2[4*c+3];
      inv[4*c]   = m14[4*c] ^ m11[4*c+1] ^ m13[4*c+2] ^ m9[4*c+3];
      inv[4*c+1] = m9[4*c] ^ m14[4*c+1] ^ m11[4*c+2] ^ m13[4*c+3];
      inv[4*c+2] = m13[4*c] ^ m9[4*c+1] ^ m14[4*c+2] ^ m11[4*c+3];
      inv[4*c+3] = m11[4*c] ^ m13[4*c+1] ^ m9[4*c+2] ^ m14[4*c+3];
    end
    for (int i = 0; i < NumBytes; i++) begin
      colOut[BlockWidth-1-ByteWidth*i -: ByteWidth] = (mode == modeDecrypt) ? inv[i] : fwd[i];
    end
  end

endmodule

// ==== src/keyExpand.sv ====
//--------------------------------------------------------------------------
// AES-128 key schedule. A keyStart pulse loads the cipher key; all eleven
// round keys are stored and keysReady rises ten cycles later.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module keyExpand (
  input  logic               clk,
  input  logic               rst,
  input  logic               keyStart,
  input  aesPkg::aesBlock_t  cipherKey,
  input  aesPkg::roundIdx_t  keySel,
  output aesPkg::aesBlock_t  roundKey,
  output logic               keysReady
);
  import aesPkg::*;

  localparam roundIdx_t KeysDone = roundIdx_t'(NumRounds + 1);

  aesBlock_t keyMem [NumRounds+1];
  aesBlock_t lastKey;
  aesBlock_t expandSrc;
  aesBlock_t nextKey;
  roundIdx_t genIdx;
  roundIdx_t rconIdx;
  logic [ByteWidth-1:0] rcon;
  logic generating;

  function automatic aesBlock_t expandStep(input aesBlock_t prev, input logic [7:0] rc);
    logic [4*ByteWidth-1:0] rotated;
    logic [4*ByteWidth-1:0] temp;
    logic [4*ByteWidth-1:0] w0, w1, w2, w3;
    rotated = {prev[23:0], prev[31:24]};
    temp = subWord(rotated) ^ {rc, 24'h0};
    w0 = prev[127:96] ^ temp;
    w1 = prev[95:64] ^ w0;
    w2 = prev[63:32] ^ w1;
    w3 = prev[31:0] ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  // key 1 is derived straight from the input key in the start cycle
  assign expandSrc = keyStart ? cipherKey : lastKey;
  assign rconIdx = keyStart ? '0 : roundIdx_t'(genIdx - 4'd1);
  assign rcon = rconTable[rconIdx];
  assign nextKey = expandStep(expandSrc, rcon);
  assign generating = (genIdx >= 4'd2) && (genIdx <= roundIdx_t'(NumRounds));

  always_ff @(posedge clk) begin
    if (rst) begin
      genIdx <= '0;
    end else if (keyStart) begin
      genIdx <= 4'd2;
    end else if (generating) begin
      genIdx <= genIdx + 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (keyStart) begin
      keyMem[0] <= cipherKey;
      keyMem[1] <= nextKey;
      lastKey <= nextKey;
    end else if (generating) begin
      keyMem[genIdx] <= nextKey;
      lastKey <= nextKey;
    end
  end

  assign roundKey = keyMem[keySel];
  assign keysReady = (genIdx == KeysDone);

endmodule

// ==== src/aesPkg.sv ====
//--------------------------------------------------------------------------
// Shared AES-128 definitions: widths, state and mode enums, the request
// struct, S-box tables, round constants and the byte substitution helpers.
//--------------------------------------------------------------------------
package aesPkg;

  localparam int BlockWidth = 128;
  localparam int ByteWidth = 8;
  localparam int NumBytes = BlockWidth / ByteWidth;
  localparam int NumRounds = 10;

  typedef logic [3:0] roundIdx_t;

  // byte 0 sits in the top bits, bytes run down each column in turn
  typedef logic [BlockWidth-1:0] aesBlock_t;

  typedef enum logic {
    modeEncrypt,
    modeDecrypt
  } aesMode_t;

  typedef enum logic [1:0] {
    stIdle,
    stExpand,
    stRounds,
    stDone
  } coreState_t;

  typedef struct packed {
    aesBlock_t block;
    aesBlock_t key;
    aesMode_t  mode;
  } aesReq_t;

  // entry 0 is the leftmost byte of each row
  localparam logic [0:255][ByteWidth-1:0] sboxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  localparam logic [0:255][ByteWidth-1:0] invSboxTable = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  // rcon for keys 1 to 10
  localparam logic [0:NumRounds-1][ByteWidth-1:0] rconTable = 80'h01020408102040801b36;

  function automatic aesBlock_t subBytes(input aesBlock_t blk);
    aesBlock_t res;
    for (int i = 0; i < NumBytes; i++) begin
      res[ByteWidth*i +: ByteWidth] = sboxTable[blk[ByteWidth*i +: ByteWidth]];
    end
    return res;
  endfunction

  function automatic aesBlock_t invSubBytes(input aesBlock_t blk);
    aesBlock_t res;
    for (int i = 0; i < NumBytes; i++) begin
      res[ByteWidth*i +: ByteWidth] = invSboxTable[blk[ByteWidth*i +: ByteWidth]];
    end
    return res;
  endfunction

  function automatic logic [4*ByteWidth-1:0] subWord(input logic [4*ByteWidth-1:0] word);
    logic [4*ByteWidth-1:0] res;
    for (int i = 0; i < 4; i++) begin
      res[ByteWidth*i +: ByteWidth] = sboxTable[word[ByteWidth*i +: ByteWidth]];
    end
    return res;
  endfunction

endpackage
